// File: design/qa_drv_csr.sv
//**************************************
// Host configuration register block
// Decodes single-cycle config writes from the receive channel and
// broadcasts the whole register state as one struct
// Trigger and start fields are one-cycle command pulses
//**************************************

module qa_drv_csr (
    input  logic                    clk,
    input  logic                    resetb,
    input  qa_pkg::rx_c0_t          rx0,
    output qa_pkg::t_csr_afu_state  csr
);

    // Base and frame address registers written by the host
    logic [63:0] dsm_base;
    logic [63:0] cntxt_base;
    logic [63:0] read_frame;
    logic [63:0] write_frame;

    logic                     dsm_base_valid;
    logic                     cntxt_base_valid;
    logic                     afu_en;
    qa_pkg::t_afu_debug_req   trigger_debug;
    qa_pkg::t_afu_enable_test enable_test;

    // True when this cycle carries a config write to the given register
    function automatic logic csr_hit(input qa_pkg::rx_c0_t req, input qa_pkg::t_csr_addr addr);
        return req.cfgvalid && (req.header == 14'(addr));
    endfunction

    // Each wide register is loaded one 32-bit half at a time
    always_ff @(posedge clk) begin
        if (csr_hit(rx0, qa_pkg::CSR_AFU_DSM_BASEL)) begin
            dsm_base[31:0] <= rx0.data;
        end
        if (csr_hit(rx0, qa_pkg::CSR_AFU_DSM_BASEH)) begin
            dsm_base[63:32] <= rx0.data;
        end
        if (csr_hit(rx0, qa_pkg::CSR_AFU_CNTXT_BASEL)) begin
            cntxt_base[31:0] <= rx0.data;
        end
        if (csr_hit(rx0, qa_pkg::CSR_AFU_CNTXT_BASEH)) begin
            cntxt_base[63:32] <= rx0.data;
        end
        if (csr_hit(rx0, qa_pkg::CSR_AFU_READ_FRAME_BASEL)) begin
            read_frame[31:0] <= rx0.data;
        end
        if (csr_hit(rx0, qa_pkg::CSR_AFU_READ_FRAME_BASEH)) begin
            read_frame[63:32] <= rx0.data;
        end
        if (csr_hit(rx0, qa_pkg::CSR_AFU_WRITE_FRAME_BASEL)) begin
            write_frame[31:0] <= rx0.data;
        end
        if (csr_hit(rx0, qa_pkg::CSR_AFU_WRITE_FRAME_BASEH)) begin
            write_frame[63:32] <= rx0.data;
        end
    end

    // Control fields
    always_ff @(posedge clk) begin
        if (!resetb) begin
            dsm_base_valid   <= 1'b0;
            cntxt_base_valid <= 1'b0;
            afu_en           <= 1'b0;
            trigger_debug    <= '0;
            enable_test      <= '0;
        end else begin
            // A base counts as valid once its low word has been written
            if (csr_hit(rx0, qa_pkg::CSR_AFU_DSM_BASEL)) begin
                dsm_base_valid <= 1'b1;
            end
            if (csr_hit(rx0, qa_pkg::CSR_AFU_CNTXT_BASEL)) begin
                cntxt_base_valid <= 1'b1;
            end
            if (csr_hit(rx0, qa_pkg::CSR_AFU_EN)) begin
                afu_en <= rx0.data[0];
            end

            // Commands last one cycle and drop back to zero on the next edge
            if (csr_hit(rx0, qa_pkg::CSR_AFU_TRIGGER_DEBUG)) begin
                trigger_debug <= rx0.data[$bits(qa_pkg::t_afu_debug_req)-1:0];
            end else begin
                trigger_debug <= '0;
            end
            if (csr_hit(rx0, qa_pkg::CSR_AFU_ENABLE_TEST)) begin
                enable_test <= rx0.data[$bits(qa_pkg::t_afu_enable_test)-1:0];
            end else begin
                enable_test <= '0;
            end
        end
    end

    // Pack everything into the broadcast struct
    always_comb begin
        csr.afu_dsm_base         = dsm_base;
        csr.afu_dsm_base_valid   = dsm_base_valid;
        csr.afu_cntxt_base       = cntxt_base;
        csr.afu_cntxt_base_valid = cntxt_base_valid;
        csr.afu_en               = afu_en;
        csr.afu_trigger_debug    = trigger_debug;
        csr.afu_enable_test      = enable_test;
        csr.afu_read_frame       = read_frame;
        csr.afu_write_frame      = write_frame;
    end

endmodule

// File: design/qa_drv_line_walker.sv
//**************************************
// Line walker of the test engine
// On a start pulse it issues a read and then a write for every cache
// line of the test and pulses done with the count at the end
//**************************************

module qa_drv_line_walker (
    input  logic                   clk,
    input  logic                   resetb,
    input  qa_pkg::t_csr_afu_state csr,
    output qa_pkg::t_tx_req        walk_req,
    input  logic                   walk_grant,
    output logic                   done,
    output logic [6:0]             line_count
);

    qa_pkg::t_walk_state state;

    // Test parameters captured at start so later CSR writes cannot disturb a walk
    logic [6:0]  count;
    logic [6:0]  idx;
    logic [63:0] rd_base;
    logic [63:0] wr_base;

    logic [6:0] start_count;
    logic       start;
    logic       accept;
    logic       last_line;

    // A start is only honoured while enabled and idle, with a nonzero count
    assign start_count = csr.afu_enable_test[7:1];
    assign start       = (state == qa_pkg::WALK_IDLE) && csr.afu_en &&
                         csr.afu_enable_test[0] && (start_count != 7'd0);
    assign accept      = walk_req.valid && walk_grant;
    assign last_line   = (idx == count - 7'd1);

    // Request is held stable until the arbiter grants it
    always_comb begin
        walk_req.valid = (state != qa_pkg::WALK_IDLE);
        if (state == qa_pkg::WALK_WR) begin
            walk_req.opcode = qa_pkg::TX_WR_LINE;
            walk_req.addr   = wr_base + {57'd0, idx};
            walk_req.data   = {25'd0, idx};
        end else begin
            walk_req.opcode = qa_pkg::TX_RD_LINE;
            walk_req.addr   = rd_base + {57'd0, idx};
            walk_req.data   = 32'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetb) begin
            state <= qa_pkg::WALK_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                state <= qa_pkg::WALK_RD;
            end else if (accept) begin
                // Losing afu_en mid-test ends the walk quietly with no done pulse
                if (!csr.afu_en) begin
                    state <= qa_pkg::WALK_IDLE;
                end else if (state == qa_pkg::WALK_RD) begin
                    state <= qa_pkg::WALK_WR;
                end else if (last_line) begin
                    state <= qa_pkg::WALK_IDLE;
                    done  <= 1'b1;
                end else begin
                    state <= qa_pkg::WALK_RD;
                end
            end
        end
    end

    // Walk bookkeeping
    always_ff @(posedge clk) begin
        if (start) begin
            count   <= start_count;
            idx     <= 7'd0;
            rd_base <= csr.afu_read_frame;
            wr_base <= csr.afu_write_frame;
        end else if (accept && (state == qa_pkg::WALK_WR)) begin
            idx <= idx + 7'd1;
        end
    end

    // Count stays latched until the next start, so it is stable with done
    assign line_count = count;

endmodule

// File: design/qa_drv_status_writer.sv
//**************************************
// Status writer of the test engine
// Captures completion and debug events into pending slots and posts
// them as line writes into the DSM once its base is valid
//**************************************

module qa_drv_status_writer (
    input  logic                   clk,
    input  logic                   resetb,
    input  qa_pkg::t_csr_afu_state csr,
    input  logic                   done,
    input  logic [6:0]             line_count,
    output qa_pkg::t_tx_req        stat_req,
    input  logic                   stat_grant
);

    // One slot per record kind
    logic                   done_pend;
    logic [6:0]             done_count;
    logic                   debug_pend;
    qa_pkg::t_afu_debug_req debug_code;

    qa_pkg::t_status_kind sel_kind;
    logic                 debug_evt;
    logic                 accept;

    assign debug_evt = (csr.afu_trigger_debug != '0);

    // Completion goes ahead of a debug snapshot when both wait
    assign sel_kind = done_pend ? qa_pkg::STAT_DONE : qa_pkg::STAT_DEBUG;
    assign accept   = stat_req.valid && stat_grant;

    always_comb begin
        stat_req.valid  = csr.afu_dsm_base_valid && (done_pend || debug_pend);
        stat_req.opcode = qa_pkg::TX_WR_LINE;
        if (sel_kind == qa_pkg::STAT_DONE) begin
            stat_req.addr = csr.afu_dsm_base + qa_pkg::DSM_DONE_OFFSET;
            stat_req.data = {25'd0, done_count};
        end else begin
            // Debug record carries the code and the current enable bit
            stat_req.addr = csr.afu_dsm_base + qa_pkg::DSM_DEBUG_OFFSET;
            stat_req.data = {27'd0, csr.afu_en, debug_code};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetb) begin
            done_pend  <= 1'b0;
            debug_pend <= 1'b0;
        end else begin
            // A fresh event on the same edge as the post keeps its slot pending
            if (done) begin
                done_pend <= 1'b1;
            end else if (accept && (sel_kind == qa_pkg::STAT_DONE)) begin
                done_pend <= 1'b0;
            end
            if (debug_evt) begin
                debug_pend <= 1'b1;
            end else if (accept && (sel_kind == qa_pkg::STAT_DEBUG)) begin
                debug_pend <= 1'b0;
            end
        end
    end

    // Slot payloads, a repeated event simply overwrites the older value
    always_ff @(posedge clk) begin
        if (done) begin
            done_count <= line_count;
        end
        if (debug_evt) begin
            debug_code <= csr.afu_trigger_debug;
        end
    end

endmodule

// File: design/qa_drv_top.sv
//**************************************
// Top level of the memory test engine
// Host config writes come in on rx0 and line requests leave on tx
// ARB_FAIR is handed down to the transmit arbiter
//**************************************

module qa_drv_top #(
    parameter int ARB_FAIR = 1
) (
    input  logic                   clk,
    input  logic                   resetb,
    input  qa_pkg::rx_c0_t         rx0,
    input  logic                   tx_almost_full,
    output qa_pkg::t_tx_req        tx,
    output qa_pkg::t_csr_afu_state csr_state
);

    // Register state shared by all consumers
    qa_pkg::t_csr_afu_state csr;

    // Walker side of the arbiter
    qa_pkg::t_tx_req walk_req;
    logic            walk_grant;

    // Completion handoff from walker to status writer
    logic       done;
    logic [6:0] line_count;

    // Status side of the arbiter
    qa_pkg::t_tx_req stat_req;
    logic            stat_grant;

    qa_drv_csr u_csr (
        .clk    (clk),
        .resetb (resetb),
        .rx0    (rx0),
        .csr    (csr)
    );

    qa_drv_line_walker u_line_walker (
        .clk        (clk),
        .resetb     (resetb),
        .csr        (csr),
        .walk_req   (walk_req),
        .walk_grant (walk_grant),
        .done       (done),
        .line_count (line_count)
    );

    qa_drv_status_writer u_status_writer (
        .clk        (clk),
        .resetb     (resetb),
        .csr        (csr),
        .done       (done),
        .line_count (line_count),
        .stat_req   (stat_req),
        .stat_grant (stat_grant)
    );

    qa_drv_tx_arb #(
        .ARB_FAIR (ARB_FAIR)
    ) u_tx_arb (
        .clk            (clk),
        .resetb         (resetb),
        .walk_req       (walk_req),
        .walk_grant     (walk_grant),
        .stat_req       (stat_req),
        .stat_grant     (stat_grant),
        .tx_almost_full (tx_almost_full),
        .tx             (tx)
    );

    // The host may observe the register state directly
    assign csr_state = csr;

endmodule

// File: design/qa_drv_tx_arb.sv
//**************************************
// Transmit arbiter of the test engine
// Merges walker and status requests onto one registered channel
// ARB_FAIR 1 alternates on contention, 0 favours the walker
//**************************************

module qa_drv_tx_arb #(
    parameter int ARB_FAIR = 1
) (
    input  logic            clk,
    input  logic            resetb,
    input  qa_pkg::t_tx_req walk_req,
    output logic            walk_grant,
    input  qa_pkg::t_tx_req stat_req,
    output logic            stat_grant,
    input  logic            tx_almost_full,
    output qa_pkg::t_tx_req tx
);

    // Set when the status writer took the most recent grant
    logic last_stat;
    logic pick_stat;

    always_comb begin
        if (walk_req.valid && stat_req.valid) begin
            pick_stat = (ARB_FAIR != 0) ? ~last_stat : 1'b0;
        end else begin
            pick_stat = stat_req.valid;
        end

        // Back-pressure blocks every grant in the same cycle
        walk_grant = !tx_almost_full && walk_req.valid && !pick_stat;
        stat_grant = !tx_almost_full && stat_req.valid && pick_stat;
    end

    always_ff @(posedge clk) begin
        if (!resetb) begin
            last_stat <= 1'b0;
            tx.valid  <= 1'b0;
        end else if (walk_grant) begin
            tx        <= walk_req;
            last_stat <= 1'b0;
        end else if (stat_grant) begin
            tx        <= stat_req;
            last_stat <= 1'b1;
        end else begin
            tx.valid <= 1'b0;
        end
    end

endmodule

// File: design/qa_pkg.sv
//**************************************
// Shared types for the memory test engine
// Holds the CSR map, the host and transmit channel structs and the
// enums of the walker and the status writer
// Every design file names these through qa_pkg:: scoped references
//**************************************

package qa_pkg;

    // Register word indices, as sent in the header of a host config write
    // The byte address seen by the host is the index shifted left by two
    typedef enum logic [13:0] {
        CSR_AFU_DSM_BASEL         = 14'h0280,
        CSR_AFU_DSM_BASEH         = 14'h0281,
        CSR_AFU_CNTXT_BASEL       = 14'h0282,
        CSR_AFU_CNTXT_BASEH       = 14'h0283,
        CSR_AFU_EN                = 14'h0284,
        CSR_AFU_TRIGGER_DEBUG     = 14'h0285,
        CSR_AFU_ENABLE_TEST       = 14'h0286,
        CSR_AFU_READ_FRAME_BASEL  = 14'h0288,
        CSR_AFU_READ_FRAME_BASEH  = 14'h0289,
        CSR_AFU_WRITE_FRAME_BASEL = 14'h028A,
        CSR_AFU_WRITE_FRAME_BASEH = 14'h028B
    } t_csr_addr;

    // Debug request code, zero means nothing was asked for
    typedef logic [3:0] t_afu_debug_req;

    // Bit 0 starts a test, bits 7 to 1 carry the line count
    typedef logic [7:0] t_afu_enable_test;

    // Host receive channel, a config write is one cycle with cfgvalid high
    typedef struct packed {
        logic        cfgvalid;
        logic [13:0] header;
        logic [31:0] data;
    } rx_c0_t;

    // Register state broadcast to every consumer of the CSR block
    typedef struct packed {
        logic [63:0]      afu_dsm_base;
        logic             afu_dsm_base_valid;
        logic [63:0]      afu_cntxt_base;
        logic             afu_cntxt_base_valid;
        logic             afu_en;
        t_afu_debug_req   afu_trigger_debug;
        t_afu_enable_test afu_enable_test;
        logic [63:0]      afu_read_frame;
        logic [63:0]      afu_write_frame;
    } t_csr_afu_state;

    typedef enum logic {
        TX_RD_LINE,
        TX_WR_LINE
    } t_tx_opcode;

    // One transmit request, the address counts cache lines and not bytes
    typedef struct packed {
        logic        valid;
        t_tx_opcode  opcode;
        logic [63:0] addr;
        logic [31:0] data;
    } t_tx_req;

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_RD,
        WALK_WR
    } t_walk_state;

    typedef enum logic {
        STAT_DONE,
        STAT_DEBUG
    } t_status_kind;

    // Line offsets of the status records inside the DSM
    localparam logic [63:0] DSM_DONE_OFFSET  = 64'd0;
    localparam logic [63:0] DSM_DEBUG_OFFSET = 64'd1;

endpackage

// File: qa_drv_top.f
design/qa_pkg.sv
design/qa_drv_csr.sv
design/qa_drv_line_walker.sv
design/qa_drv_status_writer.sv
design/qa_drv_tx_arb.sv
design/qa_drv_top.sv
sim/qa_drv_assertions.sv
sim/qa_drv_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module qa_drv_tb -f qa_drv_top.f -o qa_drv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/qa_drv_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// File: sim/qa_drv_assertions.sv
//****************************************
// Protocol assertions of the test engine
// Attached to every qa_drv_top through the bind at the end
//****************************************

module qa_drv_assertions (
    input logic                   clk,
    input logic                   resetb,
    input logic                   tx_almost_full,
    input qa_pkg::t_tx_req        tx,
    input qa_pkg::t_csr_afu_state csr_state
);
    timeunit 1ns;
    timeprecision 1ps;

    // A cycle with back-pressure lets no beat out on the next cycle
    stall_blocks_tx: assert property (@(posedge clk) disable iff (!resetb)
        tx_almost_full |=> !tx.valid)
        else $error("tx.valid high in the cycle after tx_almost_full");

    // Command pulses last exactly one cycle
    debug_pulse_short: assert property (@(posedge clk) disable iff (!resetb)
        (csr_state.afu_trigger_debug != '0) |=> (csr_state.afu_trigger_debug == '0))
        else $error("afu_trigger_debug held longer than one cycle");
    test_pulse_short: assert property (@(posedge clk) disable iff (!resetb)
        (csr_state.afu_enable_test != '0) |=> (csr_state.afu_enable_test == '0))
        else $error("afu_enable_test held longer than one cycle");

    // Synchronous reset clears the transmit channel
    reset_clears_tx: assert property (@(posedge clk) !resetb |=> !tx.valid)
        else $error("tx.valid high while in reset");

endmodule

bind qa_drv_top qa_drv_assertions u_qa_drv_assertions (
    .clk            (clk),
    .resetb         (resetb),
    .tx_almost_full (tx_almost_full),
    .tx             (tx),
    .csr_state      (csr_state)
);

// File: sim/qa_drv_tb.sv
//****************************************
// Testbench of the memory test engine
// Replays host writes from the testdata file, drives random back-pressure
// and checks the register state and every transmit beat against a model
//****************************************

module qa_drv_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk = 1'b0;
    logic                   resetb;
    logic                   tx_almost_full;
    logic                   bp_on;
    qa_pkg::rx_c0_t         rx0;
    qa_pkg::t_tx_req        tx;
    qa_pkg::t_csr_afu_state csr_state;

    // Register model and the mask of the bits that the model knows
    qa_pkg::t_csr_afu_state m;
    qa_pkg::t_csr_afu_state known;
    logic [63:0]            base_m[4];
    logic [63:0]            base_known[4];
    logic                   base_valid[4];

    // Observed beats by address range, with their order of arrival
    qa_pkg::t_tx_req rd_q[$];
    qa_pkg::t_tx_req wr_q[$];
    qa_pkg::t_tx_req dsm_q[$];
    qa_pkg::t_tx_req exp_dsm[$];
    int              rd_seq[$];
    int              wr_seq[$];
    int              dsm_seq[$];
    int              beat_seq = 0;
    int              last_wr_seq = 0;
    int              cycles = 0;
    int              limit = 500;
    logic [31:0]     rng = 32'd52505;

    qa_drv_top #(
        .ARB_FAIR (1)
    ) u_qa_drv_top (
        .clk            (clk),
        .resetb         (resetb),
        .rx0            (rx0),
        .tx_almost_full (tx_almost_full),
        .tx             (tx),
        .csr_state      (csr_state)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure();
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_tx_req(input string name, input qa_pkg::t_tx_req exp,
                                input qa_pkg::t_tx_req act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_csr(input qa_pkg::t_csr_afu_state exp,
                             input qa_pkg::t_csr_afu_state act);
        if ((act & known) !== (exp & known)) begin
            $display("Mismatch at %0t: csr_state expected %h, got %h",
                     $time, exp & known, act & known);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            report_failure();
        end
    endtask

    // A low word write also makes the base valid
    task automatic set_base(input int w, input logic hi, input logic [31:0] d);
        if (hi) begin
            base_m[w][63:32] = d;
            base_known[w][63:32] = '1;
        end else begin
            base_m[w][31:0] = d;
            base_known[w][31:0] = '1;
            base_valid[w] = 1'b1;
        end
    endtask

    // Posts every expected DSM record once the DSM base is valid
    task automatic drain_dsm();
        qa_pkg::t_tx_req exp;
        if (!m.afu_dsm_base_valid) return;
        while (dsm_q.size() < exp_dsm.size()) @(negedge clk);
        while (exp_dsm.size() > 0) begin
            exp = exp_dsm.pop_front();
            if (exp.addr == qa_pkg::DSM_DONE_OFFSET && dsm_seq[0] <= last_wr_seq) begin
                $display("Completion record arrived before the last write beat of its test");
                report_failure();
            end
            exp.addr = m.afu_dsm_base + exp.addr;
            check_tx_req("tx DSM record", exp, dsm_q.pop_front());
            void'(dsm_seq.pop_front());
        end
    endtask

    // One config write, then the register state seen one edge later
    task automatic write_reg(input logic [31:0] idx, input logic [31:0] d);
        @(negedge clk);
        rx0.cfgvalid = 1'b1;
        rx0.header   = idx[13:0];
        rx0.data     = d;
        @(negedge clk);
        rx0.cfgvalid = 1'b0;
        case (qa_pkg::t_csr_addr'(idx[13:0]))
            qa_pkg::CSR_AFU_DSM_BASEL:         set_base(0, 1'b0, d);
            qa_pkg::CSR_AFU_DSM_BASEH:         set_base(0, 1'b1, d);
            qa_pkg::CSR_AFU_CNTXT_BASEL:       set_base(1, 1'b0, d);
            qa_pkg::CSR_AFU_CNTXT_BASEH:       set_base(1, 1'b1, d);
            qa_pkg::CSR_AFU_READ_FRAME_BASEL:  set_base(2, 1'b0, d);
            qa_pkg::CSR_AFU_READ_FRAME_BASEH:  set_base(2, 1'b1, d);
            qa_pkg::CSR_AFU_WRITE_FRAME_BASEL: set_base(3, 1'b0, d);
            qa_pkg::CSR_AFU_WRITE_FRAME_BASEH: set_base(3, 1'b1, d);
            qa_pkg::CSR_AFU_EN:                m.afu_en = d[0];
            qa_pkg::CSR_AFU_ENABLE_TEST:       m.afu_enable_test = d[7:0];
            qa_pkg::CSR_AFU_TRIGGER_DEBUG: begin
                m.afu_trigger_debug = d[3:0];
                // Debug record holds the code in bits 3..0 and afu_en in bit 4
                if (d[3:0] != 4'd0) begin
                    exp_dsm.push_back('{valid: 1'b1, opcode: qa_pkg::TX_WR_LINE,
                        addr: qa_pkg::DSM_DEBUG_OFFSET, data: {27'd0, m.afu_en, d[3:0]}});
                end
            end
            default: begin
                $display("Testdata writes unknown register index %h", idx);
                report_failure();
            end
        endcase
        m.afu_dsm_base         = base_m[0];
        m.afu_dsm_base_valid   = base_valid[0];
        m.afu_cntxt_base       = base_m[1];
        m.afu_cntxt_base_valid = base_valid[1];
        m.afu_read_frame       = base_m[2];
        m.afu_write_frame      = base_m[3];
        known.afu_dsm_base     = base_known[0];
        known.afu_cntxt_base   = base_known[1];
        known.afu_read_frame   = base_known[2];
        known.afu_write_frame  = base_known[3];
        check_csr(m, csr_state);
        // Pulses are expected back at zero from the next cycle on
        m.afu_trigger_debug = '0;
        m.afu_enable_test   = '0;
        drain_dsm();
    endtask

    // Waits for the beats of one test and checks their order and contents
    task automatic check_walk(input int n);
        qa_pkg::t_tx_req exp;
        if (n == 0) begin
            repeat (30) @(negedge clk);
            check_count("beats after a disabled start", 0,
                        rd_q.size() + wr_q.size() + dsm_q.size());
            return;
        end
        while (wr_q.size() < n) @(negedge clk);
        check_count("walk beats", 2 * n, rd_q.size() + wr_q.size());
        for (int i = 0; i < n; i++) begin
            exp = '{valid: 1'b1, opcode: qa_pkg::TX_RD_LINE,
                    addr: m.afu_read_frame + 64'(i), data: 32'd0};
            check_tx_req("tx read beat", exp, rd_q[i]);
            exp = '{valid: 1'b1, opcode: qa_pkg::TX_WR_LINE,
                    addr: m.afu_write_frame + 64'(i), data: 32'(i)};
            check_tx_req("tx write beat", exp, wr_q[i]);
            if (wr_seq[i] < rd_seq[i]) begin
                $display("Write of line %0d was sent before its read", i);
                report_failure();
            end
        end
        last_wr_seq = wr_seq[n-1];
        exp_dsm.push_back('{valid: 1'b1, opcode: qa_pkg::TX_WR_LINE,
                            addr: qa_pkg::DSM_DONE_OFFSET, data: 32'(n)});
        rd_q.delete();
        wr_q.delete();
        rd_seq.delete();
        wr_seq.delete();
        // Without a valid DSM base the completion must stay pending
        if (!m.afu_dsm_base_valid) begin
            repeat (10) @(negedge clk);
            check_count("DSM beats before the DSM base is valid", 0, dsm_q.size());
        end
        drain_dsm();
    endtask

    // Sorts each transmit beat by address range and numbers it in order of arrival
    always @(negedge clk) begin
        if (resetb && tx.valid) begin
            beat_seq = beat_seq + 1;
            if (tx.addr - m.afu_read_frame < 64'd128) begin
                rd_q.push_back(tx);
                rd_seq.push_back(beat_seq);
            end else if (tx.addr - m.afu_write_frame < 64'd128) begin
                wr_q.push_back(tx);
                wr_seq.push_back(beat_seq);
            end else if (tx.addr - m.afu_dsm_base < 64'd2) begin
                dsm_q.push_back(tx);
                dsm_seq.push_back(beat_seq);
            end else begin
                $display("Transmit beat at %0t has address %h outside every range",
                         $time, tx.addr);
                report_failure();
            end
        end
    end

    always @(negedge clk) begin
        if (bp_on) begin
            rng = next_random(rng);
            tx_almost_full = rng[0];
        end else begin
            tx_almost_full = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles waiting for transmit beats", cycles);
            report_failure();
        end
    end

    initial begin
        int          fd;
        int          n;
        int          total;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        string       line;
        logic [7:0]  kinds[$];
        logic [31:0] av[$];
        logic [31:0] bv[$];
        rx0 = '0;
        resetb = 1'b0;
        bp_on = 1'b0;
        tx_almost_full = 1'b0;
        m = '0;
        known = '0;
        known.afu_dsm_base_valid   = 1'b1;
        known.afu_cntxt_base_valid = 1'b1;
        known.afu_en               = 1'b1;
        known.afu_trigger_debug    = '1;
        known.afu_enable_test      = '1;
        foreach (base_valid[i]) begin
            base_m[i] = '0;
            base_known[i] = '0;
            base_valid[i] = 1'b0;
        end
        total = 0;
        fd = $fopen("sim/qa_drv_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open sim/qa_drv_testdata.txt");
            report_failure();
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                n = $fgets(line, fd);
            end else begin
                b = '0;
                n = $fscanf(fd, " %h", a);
                if (kind == "W") n = $fscanf(fd, " %h", b);
                if (kind == "E") total += int'(a);
                kinds.push_back(kind);
                av.push_back(a);
                bv.push_back(b);
            end
        end
        $fclose(fd);
        limit = 40 * total + 500;

        repeat (8) @(negedge clk);
        resetb = 1'b1;
        @(negedge clk);
        check_csr(m, csr_state);
        foreach (kinds[i]) begin
            case (kinds[i])
                "W": write_reg(av[i], bv[i]);
                "P": bp_on = av[i][0];
                "E": check_walk(int'(av[i]));
                default: begin
                    $display("Testdata row %0d has an unknown kind", i);
                    report_failure();
                end
            endcase
        end

        // Nothing may trail the last test
        repeat (20) @(negedge clk);
        check_count("stray beats at the end", 0, rd_q.size() + wr_q.size() + dsm_q.size());
        $display("Everything OK");
        $finish;
    end

endmodule

// File: sim/qa_drv_testdata.txt
# W index data = host register write, P flag = random tx_almost_full on (1) or off (0)
# E count = expected lines of the last start, 0 means no beats at all; all values hex
W 0289 00000001
W 0288 00000100
W 028B 00000002
W 028A 00000200
W 0283 00000000
W 0282 00004000
W 0281 00000000
W 0284 00000001
P 0
W 0286 00000009
E 4
W 0280 00003000
W 0285 00000005
P 1
W 0286 0000000D
E 6
W 0284 00000000
W 0285 00000003
W 0286 00000007
E 0
W 0284 00000001
W 0285 0000000A
W 0286 0000000B
E 5
